//--- Bender.yml
package:
  name: qla_reg

sources:
  - rtl/qla_addr_pkg.sv
  - rtl/qla_board_pkg.sv
  - rtl/safety_check.sv
  - rtl/hub_regs.sv
  - rtl/motor_chan_regs.sv
  - rtl/board_regs.sv
  - rtl/reg_bus_switch.sv
  - rtl/qla_reg_top.sv
  - target: simulation
    files:
      - sim/qla_reg_tb.sv

//--- qla_reg.f
rtl/qla_addr_pkg.sv
rtl/qla_board_pkg.sv
rtl/safety_check.sv
rtl/hub_regs.sv
rtl/motor_chan_regs.sv
rtl/board_regs.sv
rtl/reg_bus_switch.sv
rtl/qla_reg_top.sv
sim/qla_reg_tb.sv

//--- rtl/board_regs.sv
// channel 0 board registers
// amplifier and power enables, trip status, board id and signature
`timescale 1ns/1ps

module board_regs (
    input  logic                                  sysclk,
    input  logic                                  rst_n,
    input  logic                                  reg_wen,
    input  logic [qla_addr_pkg::ADDR_W-1:0]       reg_waddr,
    input  logic [qla_addr_pkg::DATA_W-1:0]       reg_wdata,
    input  logic [qla_addr_pkg::ADDR_W-1:0]       reg_raddr,
    input  logic [qla_board_pkg::BOARD_ID_W-1:0]  wenid,      // rotary switch, active low
    input  logic [qla_board_pkg::NUM_AXES-1:0]    trip,
    output logic [qla_board_pkg::NUM_AXES-1:0]    amp_enable,
    output logic                                  pwr_enable,
    output logic                                  trip_clear,
    output logic [qla_addr_pkg::DATA_W-1:0]       rdata_board
);

    qla_addr_pkg::reg_addr_u                  wa;
    qla_addr_pkg::reg_addr_u                  ra;
    logic [qla_board_pkg::NUM_AXES-1:0]       amp_req;    // mask asked for by host
    logic [qla_addr_pkg::DATA_W-1:0]          status;

    assign wa = reg_waddr;
    assign ra = reg_raddr;

    // control write also clears any latched trips at the same edge
    assign trip_clear = reg_wen
                     && (wa.board_view.chan == 4'd0)
                     && (wa.board_view.offset == qla_addr_pkg::OFF_ADC_DATA);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_req    <= '0;
            pwr_enable <= 1'b0;
        end else if (trip_clear) begin
            amp_req    <= reg_wdata[qla_board_pkg::AMP_EN_LSB +: qla_board_pkg::NUM_AXES];
            pwr_enable <= reg_wdata[qla_board_pkg::PWR_EN_BIT];
        end
    end

    assign amp_enable = amp_req & ~trip;    // tripped axes forced off

    // ------------------------------------------------------------------
    // status word
    // ------------------------------------------------------------------
    always_comb begin
        status = '0;
        status[qla_board_pkg::AMP_EN_LSB +: qla_board_pkg::NUM_AXES] = amp_enable;
        status[qla_board_pkg::PWR_EN_BIT] = pwr_enable;
        status[qla_board_pkg::TRIP_LSB +: qla_board_pkg::NUM_AXES] = trip;
        status[qla_board_pkg::BOARD_ID_LSB +: qla_board_pkg::BOARD_ID_W] = ~wenid;
    end

    always_comb begin
        case (ra.board_view.offset)
            qla_addr_pkg::OFF_ADC_DATA: rdata_board = status;
            qla_addr_pkg::OFF_DAC_CTRL: rdata_board = qla_board_pkg::BOARD_SIGNATURE;
            default:                    rdata_board = '0;
        endcase
    end

endmodule

//--- rtl/hub_regs.sv
// hub register store
// sixteen 32-bit words, written from the hub space, read combinationally
`timescale 1ns/1ps

module hub_regs (
    input  logic                              sysclk,
    input  logic                              rst_n,
    input  logic                              hub_wen,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   reg_waddr,
    input  logic [qla_addr_pkg::DATA_W-1:0]   reg_wdata,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   reg_raddr,
    output logic [qla_addr_pkg::DATA_W-1:0]   rdata_hub
);

    localparam int IDX_W = $clog2(qla_addr_pkg::HUB_WORDS);

    logic [qla_addr_pkg::DATA_W-1:0] hub_mem [qla_addr_pkg::HUB_WORDS];
    qla_addr_pkg::reg_addr_u         wa;
    qla_addr_pkg::reg_addr_u         ra;

    assign wa = reg_waddr;
    assign ra = reg_raddr;

    // hub words come up cleared
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < qla_addr_pkg::HUB_WORDS; i++)
                hub_mem[i] <= '0;
        end else if (hub_wen) begin
            hub_mem[wa.hub_view.index[IDX_W-1:0]] <= reg_wdata;
        end
    end

    assign rdata_hub = hub_mem[ra.hub_view.index[IDX_W-1:0]];  // upper index bits ignored

endmodule

//--- rtl/motor_chan_regs.sv
// per-axis current command registers
// single and block writes, feedback / command read-back for axes 1..4
`timescale 1ns/1ps

module motor_chan_regs (
    input  logic                              sysclk,
    input  logic                              rst_n,
    input  logic                              reg_wen,
    input  logic                              blk_wen,
    input  logic                              blk_wstart,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   reg_waddr,
    input  logic [qla_addr_pkg::DATA_W-1:0]   reg_wdata,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   reg_raddr,
    input  logic [qla_board_pkg::NUM_AXES-1:0][qla_board_pkg::CUR_W-1:0] cur_fb,
    output logic [qla_board_pkg::NUM_AXES-1:0][qla_board_pkg::CUR_W-1:0] cur_cmd,
    output logic [qla_addr_pkg::DATA_W-1:0]   rdata_chan
);

    qla_addr_pkg::reg_addr_u                wa;
    qla_addr_pkg::reg_addr_u                ra;
    logic                                   cmd_wr;     // single dac write
    logic [qla_board_pkg::AXIS_W-1:0]       w_axis;
    logic [qla_board_pkg::AXIS_W-1:0]       r_axis;
    logic [qla_board_pkg::AXIS_W:0]         blk_cnt;    // next block slot, 0..4
    logic [qla_board_pkg::AXIS_W:0]         blk_slot;

    assign wa = reg_waddr;
    assign ra = reg_raddr;

    // channel n maps to axis index n-1
    assign w_axis = qla_board_pkg::AXIS_W'(wa.board_view.chan - 4'd1);
    assign r_axis = qla_board_pkg::AXIS_W'(ra.board_view.chan - 4'd1);

    assign cmd_wr = reg_wen
                 && (wa.board_view.offset == qla_addr_pkg::OFF_DAC_CTRL)
                 && (wa.board_view.chan != 4'd0)
                 && (wa.board_view.chan <= qla_board_pkg::NUM_AXES);

    assign blk_slot = blk_wstart ? '0 : blk_cnt;   // start word goes to axis 1

    // ------------------------------------------------------------------
    // command registers
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd <= '0;
            blk_cnt <= '0;
        end else if (blk_wen) begin
            // words past axis 4 fall on the floor
            if (blk_slot < qla_board_pkg::NUM_AXES) begin
                cur_cmd[blk_slot[qla_board_pkg::AXIS_W-1:0]] <=
                    reg_wdata[qla_board_pkg::CUR_W-1:0];
                blk_cnt <= blk_slot + 1'b1;
            end else begin
                blk_cnt <= blk_slot;
            end
        end else if (cmd_wr) begin
            cur_cmd[w_axis] <= reg_wdata[qla_board_pkg::CUR_W-1:0];
        end
    end

    // read-back, zero extended; switch only selects this for chan 1..4
    always_comb begin
        case (ra.board_view.offset)
            qla_addr_pkg::OFF_ADC_DATA: rdata_chan = {16'd0, cur_fb[r_axis]};
            qla_addr_pkg::OFF_DAC_CTRL: rdata_chan = {16'd0, cur_cmd[r_axis]};
            default:                    rdata_chan = '0;
        endcase
    end

    a_blk_bound: assert property (@(posedge sysclk) disable iff (!rst_n)
        blk_cnt <= qla_board_pkg::NUM_AXES)
        else $error("block write counter past last axis");

endmodule

//--- rtl/qla_addr_pkg.sv
// register address map for the motor controller register bus
// address spaces, channel offsets, and the two views of an address word

package qla_addr_pkg;

    // ------------------------------------------------------------------
    // bus widths
    // ------------------------------------------------------------------
    localparam int ADDR_W = 16;             // register address
    localparam int DATA_W = 32;             // register data

    // address bits 15:12 select the space
    localparam logic [3:0] SPACE_MAIN = 4'd0;   // board / per-axis registers
    localparam logic [3:0] SPACE_HUB  = 4'd1;   // hub words
    // any other space is unmapped, reads zero

    localparam int HUB_WORDS = 16;          // words in the hub store

    // ------------------------------------------------------------------
    // per-channel offsets, address bits 3:0
    // ------------------------------------------------------------------
    // chan 1..4: adc feedback read
    // chan 0: board status / control
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;
    // chan 1..4: dac current command
    // chan 0: board signature
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;

    // one address word, decoded per space
    typedef union packed {
        struct packed {
            logic [3:0] space;
            logic [3:0] rsvd;               // unused in main space
            logic [3:0] chan;               // 0 board, 1..4 axes
            logic [3:0] offset;
        } board_view;
        struct packed {
            logic [3:0]  space;
            logic [11:0] index;             // low bits pick the hub word
        } hub_view;
    } reg_addr_u;

endpackage

//--- rtl/qla_board_pkg.sv
// board level constants
// axis count, current widths, safety limit and channel 0 bit layout

package qla_board_pkg;

    localparam int NUM_AXES   = 4;
    localparam int AXIS_W     = $clog2(NUM_AXES);   // axis index bits
    localparam int CUR_W      = 16;                 // unsigned current
    localparam int BOARD_ID_W = 4;                  // rotary switch

    // over-current must persist this long before the amp is cut
    localparam int SAFETY_TRIP_CYCLES = 8;

    localparam logic [31:0] BOARD_SIGNATURE = 32'h514C_4131;   // "QLA1"

    // ------------------------------------------------------------------
    // channel 0 status / control word
    // ------------------------------------------------------------------
    localparam int AMP_EN_LSB   = 0;    // amp enables 3:0
    localparam int PWR_EN_BIT   = 8;    // motor power
    localparam int TRIP_LSB     = 16;   // safety trips 19:16
    localparam int BOARD_ID_LSB = 24;   // board id 27:24

endpackage

//--- rtl/qla_reg_top.sv
// register bus core of the motor controller board
// bus switch, hub store, axis and board registers, per-axis safety checks
`timescale 1ns/1ps

module qla_reg_top (
    input  logic                                  sysclk,
    input  logic                                  rst_n,
    input  logic                                  fw_reg_wen,
    input  logic                                  fw_blk_wen,
    input  logic                                  fw_blk_wstart,
    input  logic [qla_addr_pkg::ADDR_W-1:0]       fw_reg_waddr,
    input  logic [qla_addr_pkg::DATA_W-1:0]       fw_reg_wdata,
    input  logic [qla_addr_pkg::ADDR_W-1:0]       fw_reg_raddr,
    input  logic                                  eth_reg_wen,
    input  logic                                  eth_blk_wen,
    input  logic                                  eth_blk_wstart,
    input  logic [qla_addr_pkg::ADDR_W-1:0]       eth_reg_waddr,
    input  logic [qla_addr_pkg::DATA_W-1:0]       eth_reg_wdata,
    input  logic [qla_addr_pkg::ADDR_W-1:0]       eth_reg_raddr,
    input  logic                                  eth_read_en,
    input  logic [qla_board_pkg::BOARD_ID_W-1:0]  wenid,
    input  logic [qla_board_pkg::NUM_AXES-1:0][qla_board_pkg::CUR_W-1:0] cur_fb,
    output logic [qla_addr_pkg::DATA_W-1:0]       reg_rdata,
    output logic [qla_board_pkg::NUM_AXES-1:0][qla_board_pkg::CUR_W-1:0] cur_cmd,
    output logic [qla_board_pkg::NUM_AXES-1:0]    amp_enable,
    output logic                                  pwr_enable
);

    // shared bus after the switch
    logic                              reg_wen;
    logic                              hub_wen;
    logic                              blk_wen;
    logic                              blk_wstart;
    logic [qla_addr_pkg::ADDR_W-1:0]   reg_waddr;
    logic [qla_addr_pkg::ADDR_W-1:0]   reg_raddr;
    logic [qla_addr_pkg::DATA_W-1:0]   reg_wdata;
    logic [qla_addr_pkg::DATA_W-1:0]   rdata_hub;
    logic [qla_addr_pkg::DATA_W-1:0]   rdata_chan;
    logic [qla_addr_pkg::DATA_W-1:0]   rdata_board;
    logic [qla_board_pkg::NUM_AXES-1:0] trip;
    logic                              trip_clear;

    reg_bus_switch u_switch (
        .sysclk, .rst_n,
        .fw_reg_wen, .fw_blk_wen, .fw_blk_wstart,
        .fw_reg_waddr, .fw_reg_wdata, .fw_reg_raddr,
        .eth_reg_wen, .eth_blk_wen, .eth_blk_wstart,
        .eth_reg_waddr, .eth_reg_wdata, .eth_reg_raddr, .eth_read_en,
        .rdata_hub, .rdata_chan, .rdata_board,
        .reg_wen, .hub_wen, .blk_wen, .blk_wstart,
        .reg_waddr, .reg_raddr, .reg_wdata, .reg_rdata
    );

    hub_regs u_hub (
        .sysclk, .rst_n, .hub_wen, .reg_waddr, .reg_wdata, .reg_raddr, .rdata_hub
    );

    motor_chan_regs u_chan (
        .sysclk, .rst_n, .reg_wen, .blk_wen, .blk_wstart,
        .reg_waddr, .reg_wdata, .reg_raddr, .cur_fb, .cur_cmd, .rdata_chan
    );

    board_regs u_board (
        .sysclk, .rst_n, .reg_wen, .reg_waddr, .reg_wdata, .reg_raddr,
        .wenid, .trip, .amp_enable, .pwr_enable, .trip_clear, .rdata_board
    );

    // ------------------------------------------------------------------
    // one safety check per axis
    // ------------------------------------------------------------------
    for (genvar i = 0; i < qla_board_pkg::NUM_AXES; i++) begin : g_safety
        safety_check u_safe (
            .sysclk     (sysclk),
            .rst_n      (rst_n),
            .cur_fb     (cur_fb[i]),
            .cur_cmd    (cur_cmd[i]),
            .trip_clear (trip_clear),
            .trip       (trip[i])
        );
    end

endmodule

//--- rtl/reg_bus_switch.sv
// two-master register bus switch
// merges firewire and ethernet strobes, decodes write space,
// registers the read word selected by space and channel
`timescale 1ns/1ps

module reg_bus_switch (
    input  logic                              sysclk,
    input  logic                              rst_n,
    input  logic                              fw_reg_wen,
    input  logic                              fw_blk_wen,
    input  logic                              fw_blk_wstart,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   fw_reg_waddr,
    input  logic [qla_addr_pkg::DATA_W-1:0]   fw_reg_wdata,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   fw_reg_raddr,
    input  logic                              eth_reg_wen,
    input  logic                              eth_blk_wen,
    input  logic                              eth_blk_wstart,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   eth_reg_waddr,
    input  logic [qla_addr_pkg::DATA_W-1:0]   eth_reg_wdata,
    input  logic [qla_addr_pkg::ADDR_W-1:0]   eth_reg_raddr,
    input  logic                              eth_read_en,    // eth owns read addr
    input  logic [qla_addr_pkg::DATA_W-1:0]   rdata_hub,
    input  logic [qla_addr_pkg::DATA_W-1:0]   rdata_chan,
    input  logic [qla_addr_pkg::DATA_W-1:0]   rdata_board,
    output logic                              reg_wen,        // main space only
    output logic                              hub_wen,
    output logic                              blk_wen,
    output logic                              blk_wstart,
    output logic [qla_addr_pkg::ADDR_W-1:0]   reg_waddr,
    output logic [qla_addr_pkg::ADDR_W-1:0]   reg_raddr,
    output logic [qla_addr_pkg::DATA_W-1:0]   reg_wdata,
    output logic [qla_addr_pkg::DATA_W-1:0]   reg_rdata
);

    logic                      eth_wr;      // ethernet writing this cycle
    logic                      any_wen;
    qla_addr_pkg::reg_addr_u   wa;
    qla_addr_pkg::reg_addr_u   ra;
    logic [qla_addr_pkg::DATA_W-1:0] rd_sel;

    // ------------------------------------------------------------------
    // write side merge
    // ------------------------------------------------------------------
    assign eth_wr     = eth_reg_wen | eth_blk_wen;
    assign reg_waddr  = eth_wr ? eth_reg_waddr : fw_reg_waddr;
    assign reg_wdata  = eth_wr ? eth_reg_wdata : fw_reg_wdata;
    assign blk_wen    = fw_blk_wen | eth_blk_wen;
    assign blk_wstart = fw_blk_wstart | eth_blk_wstart;
    assign any_wen    = fw_reg_wen | eth_reg_wen;

    assign wa      = reg_waddr;
    assign reg_wen = any_wen && (wa.board_view.space == qla_addr_pkg::SPACE_MAIN);
    assign hub_wen = any_wen && (wa.board_view.space == qla_addr_pkg::SPACE_HUB);

    // ------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------
    assign reg_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;
    assign ra        = reg_raddr;

    always_comb begin
        rd_sel = '0;                        // unmapped reads zero
        if (ra.board_view.space == qla_addr_pkg::SPACE_HUB) begin
            rd_sel = rdata_hub;
        end else if (ra.board_view.space == qla_addr_pkg::SPACE_MAIN) begin
            if (ra.board_view.chan == 4'd0)
                rd_sel = rdata_board;       // channel 0
            else if (ra.board_view.chan <= qla_board_pkg::NUM_AXES)
                rd_sel = rdata_chan;        // axes 1..4
        end
    end

    // one cycle read latency
    always_ff @(posedge sysclk) begin
        if (!rst_n)
            reg_rdata <= '0;
        else
            reg_rdata <= rd_sel;
    end

    // masters own the bus cycle by cycle, never together
    a_one_writer: assert property (@(posedge sysclk) disable iff (!rst_n)
        !((fw_reg_wen | fw_blk_wen) && eth_wr))
        else $error("firewire and ethernet write in the same cycle");

endmodule

//--- rtl/safety_check.sv
// over-current detector for one axis
// trips after a run of cycles with feedback above twice the command
`timescale 1ns/1ps

module safety_check (
    input  logic                              sysclk,
    input  logic                              rst_n,
    input  logic [qla_board_pkg::CUR_W-1:0]   cur_fb,
    input  logic [qla_board_pkg::CUR_W-1:0]   cur_cmd,
    input  logic                              trip_clear,   // channel 0 control write
    output logic                              trip
);

    localparam int CNT_W = $clog2(qla_board_pkg::SAFETY_TRIP_CYCLES);

    logic             over;
    logic [CNT_W-1:0] over_cnt;     // consecutive cycles over the limit

    // 2 * cmd needs one more bit
    assign over = {1'b0, cur_fb} > {cur_cmd, 1'b0};

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            over_cnt <= '0;
            trip     <= 1'b0;
        end else if (trip_clear) begin
            over_cnt <= '0;
            trip     <= 1'b0;
        end else if (over) begin
            if (over_cnt == CNT_W'(qla_board_pkg::SAFETY_TRIP_CYCLES - 1))
                trip <= 1'b1;               // latched until cleared
            else
                over_cnt <= over_cnt + 1'b1;
        end else begin
            over_cnt <= '0;                 // run broken
        end
    end

endmodule

//--- sim/qla_reg_tb.sv
// directed testbench for the register bus core
// clock, reset, bus access tasks and one task per test
`timescale 1ns/1ps

module qla_reg_tb;

    logic        sysclk, rst_n;
    logic        fw_reg_wen, fw_blk_wen, fw_blk_wstart;
    logic        eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_read_en;
    logic [15:0] fw_reg_waddr, fw_reg_raddr, eth_reg_waddr, eth_reg_raddr;
    logic [31:0] fw_reg_wdata, eth_reg_wdata, reg_rdata;
    logic [3:0]  wenid, amp_enable;
    logic        pwr_enable;
    logic [3:0][15:0] cur_fb, cur_cmd;
    integer      seed;
    logic [31:0] exp_cmd [4];               // expected command per axis

    qla_reg_top dut_i (
        .sysclk, .rst_n, .fw_reg_wen, .fw_blk_wen, .fw_blk_wstart,
        .fw_reg_waddr, .fw_reg_wdata, .fw_reg_raddr,
        .eth_reg_wen, .eth_blk_wen, .eth_blk_wstart,
        .eth_reg_waddr, .eth_reg_wdata, .eth_reg_raddr, .eth_read_en,
        .wenid, .cur_fb, .reg_rdata, .cur_cmd, .amp_enable, .pwr_enable
    );

    always #4 sysclk = ~sysclk;             // 8 ns period

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [15:0] main_addr(input logic [3:0] chan, input logic [3:0] off);
        return {qla_addr_pkg::SPACE_MAIN, 4'h0, chan, off};
    endfunction

    function automatic logic [15:0] hub_addr(input logic [3:0] idx);
        return {qla_addr_pkg::SPACE_HUB, 8'h00, idx};
    endfunction

    // channel 0 status layout
    function automatic logic [31:0] status_word(input logic [3:0] amp, input logic pwr,
                                                input logic [3:0] trip, input logic [3:0] id);
        logic [31:0] w;
        w = '0;
        w[qla_board_pkg::AMP_EN_LSB +: 4]   = amp;
        w[qla_board_pkg::PWR_EN_BIT]        = pwr;
        w[qla_board_pkg::TRIP_LSB +: 4]     = trip;
        w[qla_board_pkg::BOARD_ID_LSB +: 4] = ~id;  // switch is active low
        return w;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(negedge sysclk);       // three edges in reset
        rst_n = 1'b1;
    endtask

    // one-cycle strobe from either master
    task automatic write_reg(input bit use_eth, input logic [15:0] addr, input logic [31:0] data);
        if (use_eth) begin
            eth_reg_waddr = addr;
            eth_reg_wdata = data;
            eth_reg_wen   = 1'b1;
        end else begin
            fw_reg_waddr = addr;
            fw_reg_wdata = data;
            fw_reg_wen   = 1'b1;
        end
        @(negedge sysclk);
        fw_reg_wen  = 1'b0;
        eth_reg_wen = 1'b0;
    endtask

    // rdata is registered, so it is valid one edge later
    task automatic expect_read(input bit use_eth, input logic [15:0] addr,
                               input logic [31:0] exp);
        if (use_eth)
            eth_reg_raddr = addr;
        else
            fw_reg_raddr = addr;
        eth_read_en = use_eth;
        @(negedge sysclk);
        check_val($sformatf("reg_rdata at %h", addr), reg_rdata, exp);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic test_fw_access();
        logic [31:0] wd;
        logic [15:0] fb [4];
        for (int ch = 1; ch <= 4; ch++) begin
            wd = $random(seed);
            write_reg(0, main_addr(4'(ch), qla_addr_pkg::OFF_DAC_CTRL), wd);
            exp_cmd[ch-1] = {16'h0, wd[15:0]};  // zero-extended read-back
            expect_read(0, main_addr(4'(ch), qla_addr_pkg::OFF_DAC_CTRL), exp_cmd[ch-1]);
            check_val($sformatf("cur_cmd[%0d]", ch-1), {16'h0, cur_cmd[ch-1]}, exp_cmd[ch-1]);
        end
        for (int i = 0; i < 4; i++) begin
            wd = $random(seed);
            fb[i] = wd[15:0];
            cur_fb[i] = fb[i];
        end
        for (int ch = 1; ch <= 4; ch++)
            expect_read(0, main_addr(4'(ch), qla_addr_pkg::OFF_ADC_DATA), {16'h0, fb[ch-1]});
    endtask

    task automatic test_eth_arbitration();
        logic [31:0] fw_val, eth_val;
        fw_val  = $random(seed);
        eth_val = $random(seed);
        fw_reg_waddr = main_addr(1, qla_addr_pkg::OFF_DAC_CTRL);   // presented without a strobe
        fw_reg_wdata = fw_val;
        write_reg(1, main_addr(2, qla_addr_pkg::OFF_DAC_CTRL), eth_val);
        exp_cmd[1] = {16'h0, eth_val[15:0]};
        check_val("cur_cmd[1]", {16'h0, cur_cmd[1]}, exp_cmd[1]);
        check_val("cur_cmd[0]", {16'h0, cur_cmd[0]}, exp_cmd[0]);
        fw_reg_raddr = main_addr(1, qla_addr_pkg::OFF_DAC_CTRL);
        expect_read(1, main_addr(2, qla_addr_pkg::OFF_DAC_CTRL), exp_cmd[1]);
        expect_read(0, main_addr(1, qla_addr_pkg::OFF_DAC_CTRL), exp_cmd[0]);  // eth addr held
    endtask

    task automatic test_block_write();
        logic [31:0] words [5];
        for (int i = 0; i < 5; i++)
            words[i] = $random(seed);
        fw_blk_wstart = 1'b1;
        fw_blk_wen    = 1'b1;
        for (int i = 0; i < 5; i++) begin   // fifth word is one too many
            fw_reg_wdata = words[i];
            @(negedge sysclk);
            fw_blk_wstart = 1'b0;
        end
        fw_blk_wen = 1'b0;
        for (int i = 0; i < 4; i++) begin
            exp_cmd[i] = {16'h0, words[i][15:0]};
            check_val($sformatf("cur_cmd[%0d]", i), {16'h0, cur_cmd[i]}, exp_cmd[i]);
            expect_read(0, main_addr(4'(i + 1), qla_addr_pkg::OFF_DAC_CTRL), exp_cmd[i]);
        end
    endtask

    task automatic test_hub_space();
        logic [31:0] hub_exp [16];
        for (int i = 0; i < 16; i++) begin
            hub_exp[i] = $random(seed);
            write_reg(i % 2, hub_addr(4'(i)), hub_exp[i]);     // both masters take turns
        end
        for (int i = 0; i < 16; i++)
            expect_read(0, hub_addr(4'(i)), hub_exp[i]);
        expect_read(0, 16'h2001, 32'h0);    // unmapped spaces
        expect_read(1, 16'hF010, 32'h0);
        expect_read(0, main_addr(5, qla_addr_pkg::OFF_DAC_CTRL), 32'h0);   // no axis 5
    endtask

    task automatic test_safety_trip();
        logic [15:0] cmd;
        logic [31:0] ctl;
        int          ax, cycles;
        cmd = 16'h0100;
        ax  = 2;
        cur_fb = '0;
        for (int i = 0; i < 4; i++) begin
            write_reg(0, main_addr(4'(i + 1), qla_addr_pkg::OFF_DAC_CTRL), {16'h0, cmd});
            exp_cmd[i] = {16'h0, cmd};
        end
        for (int i = 0; i < 4; i++)
            check_val($sformatf("cur_cmd[%0d]", i), {16'h0, cur_cmd[i]}, exp_cmd[i]);
        ctl = '0;
        ctl[qla_board_pkg::AMP_EN_LSB +: 4] = 4'hF;
        ctl[qla_board_pkg::PWR_EN_BIT]      = 1'b1;
        write_reg(1, main_addr(0, qla_addr_pkg::OFF_ADC_DATA), ctl);   // also clears old trips
        check_val("amp_enable", {28'h0, amp_enable}, 32'hF);
        check_val("pwr_enable", {31'h0, pwr_enable}, 32'h1);
        cur_fb[ax] = 16'(2 * cmd + 1);      // just over the limit
        cycles = 0;
        while (amp_enable[ax] !== 1'b0 && cycles < 4 * qla_board_pkg::SAFETY_TRIP_CYCLES) begin
            @(negedge sysclk);
            cycles++;
        end
        assert (amp_enable[ax] === 1'b0) else begin
            $display("amp_enable of axis %0d never fell under over-current", ax);
            abort_run();
        end
        assert (cycles == qla_board_pkg::SAFETY_TRIP_CYCLES) else begin
            $display("axis %0d tripped after %0d cycles instead of %0d", ax, cycles,
                     qla_board_pkg::SAFETY_TRIP_CYCLES);
            abort_run();
        end
        check_val("amp_enable", {28'h0, amp_enable}, {28'h0, 4'hF ^ (4'b1 << ax)});
        expect_read(0, main_addr(0, qla_addr_pkg::OFF_ADC_DATA),
                    status_word(4'hF ^ (4'b1 << ax), 1'b1, 4'b1 << ax, wenid));
        cur_fb[ax] = 16'(2 * cmd);          // exactly twice is still legal
        write_reg(1, main_addr(0, qla_addr_pkg::OFF_ADC_DATA), ctl);
        expect_read(0, main_addr(0, qla_addr_pkg::OFF_ADC_DATA),
                    status_word(4'hF, 1'b1, 4'h0, wenid));
        for (int i = 0; i < 3 * qla_board_pkg::SAFETY_TRIP_CYCLES; i++) begin
            @(negedge sysclk);
            check_val("amp_enable", {28'h0, amp_enable}, 32'hF);
        end
    endtask

    task automatic test_reset_status();
        cur_fb = '0;                        // keep zero commands from tripping
        wenid  = 4'b0110;
        apply_reset();
        check_val("reg_rdata", reg_rdata, 32'h0);
        for (int i = 0; i < 4; i++)
            check_val($sformatf("cur_cmd[%0d]", i), {16'h0, cur_cmd[i]}, 32'h0);
        check_val("amp_enable", {28'h0, amp_enable}, 32'h0);
        check_val("pwr_enable", {31'h0, pwr_enable}, 32'h0);
        expect_read(0, main_addr(0, qla_addr_pkg::OFF_ADC_DATA),
                    status_word(4'h0, 1'b0, 4'h0, wenid));
        expect_read(0, main_addr(0, qla_addr_pkg::OFF_DAC_CTRL), qla_board_pkg::BOARD_SIGNATURE);
        expect_read(1, hub_addr(4'd7), 32'h0);
    endtask

    // ----------------------------------------------------------------------
    // run
    // ----------------------------------------------------------------------
    initial begin
        seed   = 32'h2906_fccc;
        sysclk = 1'b0;
        rst_n  = 1'b0;
        {fw_reg_wen, fw_blk_wen, fw_blk_wstart}    = '0;
        {eth_reg_wen, eth_blk_wen, eth_blk_wstart} = '0;
        {fw_reg_waddr, fw_reg_raddr, eth_reg_waddr, eth_reg_raddr} = '0;
        {fw_reg_wdata, eth_reg_wdata} = '0;
        eth_read_en = 1'b0;
        wenid  = 4'b1010;
        cur_fb = '0;
        for (int i = 0; i < 4; i++)
            exp_cmd[i] = '0;
        apply_reset();
        test_fw_access();
        test_eth_arbitration();
        test_block_write();
        test_hub_space();
        test_safety_trip();
        test_reset_status();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
